//--- verilog/filter_pkg.sv
package filter_pkg;

   // Stream token kinds
   typedef enum logic [1:0] {
      dtype_frame_start = 2'd0,
      dtype_pixel       = 2'd1,
      dtype_meta        = 2'd2,
      dtype_frame_end   = 2'd3
   } dtype_t;

   localparam int pixel_width      = 8;   // Default for top-level PIXEL_WIDTH
   localparam int coeff_width      = 8;
   localparam int coeff_frac_width = 7;   // 128 is unity gain
   localparam int kernel_size      = 3;
   localparam int pipe_latency     = 4;   // Stream in to stream out, in clocks

   // APB register map
   localparam logic [7:0] addr_ctrl   = 8'h00;   // Bit 0 is enable
   localparam logic [7:0] addr_coeff0 = 8'h04;
   localparam logic [7:0] addr_coeff1 = 8'h08;
   localparam logic [7:0] addr_coeff2 = 8'h0C;
   localparam logic [7:0] addr_cols   = 8'h10;

endpackage

//--- verilog/filter_regs.sv
`timescale 1ns/100ps

module filter_regs #(
   parameter int MAX_COLS = 64,
   localparam int COL_WIDTH = $clog2(MAX_COLS + 1)
) (
   input  logic                  clk,
   input  logic                  resetb,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [7:0]            paddr,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic                  enable,
   output logic [filter_pkg::kernel_size-1:0][filter_pkg::coeff_width-1:0] coeffs,
   output logic [COL_WIDTH-1:0]  num_cols
);

   localparam logic [filter_pkg::coeff_width-1:0] COEFF_ONE =
      filter_pkg::coeff_width'(1 << filter_pkg::coeff_frac_width);

   logic addr_hit;
   logic wr_en;

   // Read mux that also flags mapped addresses
   always_comb begin
      addr_hit = 1'b1;
      prdata   = '0;
      case (paddr)
         filter_pkg::addr_ctrl:   prdata = {31'b0, enable};
         filter_pkg::addr_coeff0: prdata = {24'b0, coeffs[0]};
         filter_pkg::addr_coeff1: prdata = {24'b0, coeffs[1]};
         filter_pkg::addr_coeff2: prdata = {24'b0, coeffs[2]};
         filter_pkg::addr_cols:   prdata = {{(32 - COL_WIDTH){1'b0}}, num_cols};
         default:                 addr_hit = 1'b0;
      endcase
   end

   assign pready  = 1'b1;                              // Zero wait states
   assign pslverr = psel && penable && !addr_hit;
   assign wr_en   = psel && penable && pwrite && addr_hit;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         enable    <= 1'b0;
         coeffs[0] <= '0;                              // Identity kernel
         coeffs[1] <= COEFF_ONE;
         coeffs[2] <= '0;
         num_cols  <= COL_WIDTH'(MAX_COLS);
      end else if (wr_en) begin
         case (paddr)
            filter_pkg::addr_ctrl:   enable    <= pwdata[0];
            filter_pkg::addr_coeff0: coeffs[0] <= pwdata[filter_pkg::coeff_width-1:0];
            filter_pkg::addr_coeff1: coeffs[1] <= pwdata[filter_pkg::coeff_width-1:0];
            filter_pkg::addr_coeff2: coeffs[2] <= pwdata[filter_pkg::coeff_width-1:0];
            filter_pkg::addr_cols:   num_cols  <= pwdata[COL_WIDTH-1:0];
            default:                 ;
         endcase
      end
   end

endmodule

//--- verilog/stream_decode.sv
`timescale 1ns/100ps

module stream_decode #(
   parameter int MAX_COLS = 64,
   localparam int COL_WIDTH = $clog2(MAX_COLS + 1),
   localparam int IDX_WIDTH = $clog2(MAX_COLS)
) (
   input  logic                clk,
   input  logic                resetb,
   input  logic                enable,
   input  logic [COL_WIDTH-1:0] num_cols,
   input  logic                dvi,
   input  filter_pkg::dtype_t  dtypei,
   output logic                pix_accept,
   output logic [IDX_WIDTH-1:0] col_idx,
   output logic                win_valid,
   output logic                keep
);

   logic                 in_frame;
   logic [IDX_WIDTH-1:0] col_cnt;
   logic [1:0]           row_cnt;                     // Saturates at 2
   logic [COL_WIDTH-1:0] col_next;
   logic                 frame_start;
   logic                 frame_end;

   assign frame_start = dvi && (dtypei == filter_pkg::dtype_frame_start);
   assign frame_end   = dvi && (dtypei == filter_pkg::dtype_frame_end);
   assign pix_accept  = dvi && (dtypei == filter_pkg::dtype_pixel) && in_frame;
   assign col_next    = COL_WIDTH'(col_cnt) + COL_WIDTH'(1);
   assign col_idx     = col_cnt;

   // Window is complete once two full rows and two columns are behind it
   assign win_valid = pix_accept && (row_cnt == 2'd2) && (col_cnt >= IDX_WIDTH'(2));

   // Border pixels are dropped only while filtering
   assign keep = enable ? (dvi && (!pix_accept || win_valid)) : dvi;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         in_frame <= 1'b0;
         col_cnt  <= '0;
         row_cnt  <= '0;
      end else if (frame_start) begin
         in_frame <= 1'b1;
         col_cnt  <= '0;
         row_cnt  <= '0;
      end else if (frame_end) begin
         in_frame <= 1'b0;
      end else if (pix_accept) begin
         if (col_next >= num_cols) begin              // End of row
            col_cnt <= '0;
            if (row_cnt != 2'd2) begin
               row_cnt <= row_cnt + 2'd1;
            end
         end else begin
            col_cnt <= col_cnt + IDX_WIDTH'(1);
         end
      end
   end

endmodule

//--- verilog/kernel_window.sv
`timescale 1ns/100ps

module kernel_window #(
   parameter int PIXEL_WIDTH = filter_pkg::pixel_width,
   parameter int MAX_COLS    = 64,
   localparam int IDX_WIDTH  = $clog2(MAX_COLS)
) (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   pix_accept,
   input  logic [IDX_WIDTH-1:0]   col_idx,
   input  logic [PIXEL_WIDTH-1:0] datai,
   output logic [filter_pkg::kernel_size-1:0][filter_pkg::kernel_size-1:0]
                [PIXEL_WIDTH-1:0] window
);

   localparam int K = filter_pkg::kernel_size;

   // Previous row and the row before it
   logic [PIXEL_WIDTH-1:0] line_prev  [MAX_COLS];
   logic [PIXEL_WIDTH-1:0] line_prev2 [MAX_COLS];
   logic [PIXEL_WIDTH-1:0] above1;
   logic [PIXEL_WIDTH-1:0] above2;

   assign above1 = line_prev[col_idx];                // Asynchronous read
   assign above2 = line_prev2[col_idx];

   always_ff @(posedge clk) begin
      if (pix_accept) begin
         line_prev[col_idx]  <= datai;
         line_prev2[col_idx] <= above1;                // Row ages by one
      end
   end

   // Row 0 holds the oldest row and column K-1 the newest pixel
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         window <= '0;
      end else if (pix_accept) begin
         for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K - 1; c++) begin
               window[r][c] <= window[r][c+1];
            end
         end
         window[0][K-1] <= above2;
         window[1][K-1] <= above1;
         window[2][K-1] <= datai;
      end
   end

endmodule

//--- verilog/filter1d.sv
`timescale 1ns/100ps

module filter1d #(
   parameter int PIXEL_WIDTH = filter_pkg::pixel_width
) (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic [filter_pkg::kernel_size-1:0][filter_pkg::coeff_width-1:0] coeffs,
   input  logic [filter_pkg::kernel_size-1:0][PIXEL_WIDTH-1:0] taps,
   output logic [PIXEL_WIDTH-1:0] datao
);

   // Room for three full-scale products
   localparam int SUM_WIDTH = PIXEL_WIDTH + filter_pkg::coeff_width + 2;
   localparam logic [PIXEL_WIDTH-1:0] PIX_MAX = {PIXEL_WIDTH{1'b1}};

   logic [SUM_WIDTH-1:0] acc;
   logic [SUM_WIDTH-1:0] scaled;
   logic                 sat;

   always_comb begin
      acc = '0;
      for (int i = 0; i < filter_pkg::kernel_size; i++) begin
         acc = acc + SUM_WIDTH'(taps[i]) * SUM_WIDTH'(coeffs[i]);
      end
      scaled = acc >> filter_pkg::coeff_frac_width;   // Drop fraction bits
   end

   assign sat = scaled > SUM_WIDTH'(PIX_MAX);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         datao <= '0;
      end else begin
         datao <= sat ? PIX_MAX : scaled[PIXEL_WIDTH-1:0];
      end
   end

endmodule

//--- verilog/filter2d_execute.sv
`timescale 1ns/100ps

module filter2d_execute #(
   parameter int PIXEL_WIDTH = filter_pkg::pixel_width
) (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic [filter_pkg::kernel_size-1:0][filter_pkg::coeff_width-1:0] coeffs,
   input  logic [filter_pkg::kernel_size-1:0][filter_pkg::kernel_size-1:0]
                [PIXEL_WIDTH-1:0] window,
   output logic [PIXEL_WIDTH-1:0] datao
);

   // Horizontal results, one per window row
   logic [filter_pkg::kernel_size-1:0][PIXEL_WIDTH-1:0] row_out;

   filter1d #(.PIXEL_WIDTH(PIXEL_WIDTH)) row_filt0 (
      .clk    (clk),
      .resetb (resetb),
      .coeffs (coeffs),
      .taps   (window[0]),
      .datao  (row_out[0])
   );

   filter1d #(.PIXEL_WIDTH(PIXEL_WIDTH)) row_filt1 (
      .clk    (clk),
      .resetb (resetb),
      .coeffs (coeffs),
      .taps   (window[1]),
      .datao  (row_out[1])
   );

   filter1d #(.PIXEL_WIDTH(PIXEL_WIDTH)) row_filt2 (
      .clk    (clk),
      .resetb (resetb),
      .coeffs (coeffs),
      .taps   (window[2]),
      .datao  (row_out[2])
   );

   // Vertical pass over the row results gives the centre response
   filter1d #(.PIXEL_WIDTH(PIXEL_WIDTH)) col_filt (
      .clk    (clk),
      .resetb (resetb),
      .coeffs (coeffs),
      .taps   (row_out),
      .datao  (datao)
   );

endmodule

//--- verilog/delay_line.sv
`timescale 1ns/100ps

module delay_line #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 3
) (
   input  logic     clk,
   input  logic     resetb,
   input  payload_t din,
   output payload_t dout
);

   payload_t stage [DEPTH];

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage[i] <= payload_t'(0);
         end
      end else begin
         stage[0] <= din;
         for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign dout = stage[DEPTH-1];                      // Oldest entry

endmodule

//--- verilog/filter_result.sv
`timescale 1ns/100ps

module filter_result #(
   parameter int PIXEL_WIDTH = filter_pkg::pixel_width
) (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   enable,
   input  logic                   keep_d,
   input  filter_pkg::dtype_t     dtype_d,
   input  logic [PIXEL_WIDTH-1:0] raw_d,
   input  logic [PIXEL_WIDTH-1:0] filt_data,
   output logic                   dvo,
   output filter_pkg::dtype_t     dtypeo,
   output logic [PIXEL_WIDTH-1:0] datao
);

   logic use_filt;

   // Only pixels take the filtered value, and only while filtering
   assign use_filt = enable && (dtype_d == filter_pkg::dtype_pixel);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo    <= 1'b0;
         dtypeo <= filter_pkg::dtype_t'(0);
         datao  <= '0;
      end else begin
         dvo <= keep_d;
         if (keep_d) begin                             // Hold bus between tokens
            dtypeo <= dtype_d;
            datao  <= use_filt ? filt_data : raw_d;
         end
      end
   end

endmodule

//--- verilog/filter2d_top.sv
`timescale 1ns/100ps

module filter2d_top #(
   parameter int PIXEL_WIDTH = filter_pkg::pixel_width,
   parameter int MAX_COLS    = 64,
   localparam int COL_WIDTH  = $clog2(MAX_COLS + 1),
   localparam int IDX_WIDTH  = $clog2(MAX_COLS)
) (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [7:0]             paddr,
   input  logic [31:0]            pwdata,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr,
   input  logic                   dvi,
   input  filter_pkg::dtype_t     dtypei,
   input  logic [PIXEL_WIDTH-1:0] datai,
   output logic                   dvo,
   output filter_pkg::dtype_t     dtypeo,
   output logic [PIXEL_WIDTH-1:0] datao
);

   localparam int SIDE_DEPTH = filter_pkg::pipe_latency - 1;   // Output register is the last

   logic                 enable;
   logic [filter_pkg::kernel_size-1:0][filter_pkg::coeff_width-1:0] coeffs;
   logic [COL_WIDTH-1:0] num_cols;
   logic                 pix_accept;
   logic [IDX_WIDTH-1:0] col_idx;
   logic                 keep;
   logic [filter_pkg::kernel_size-1:0][filter_pkg::kernel_size-1:0]
         [PIXEL_WIDTH-1:0] window;
   logic [PIXEL_WIDTH-1:0] filt_data;
   filter_pkg::dtype_t   dtype_in;
   filter_pkg::dtype_t   dtype_d;
   logic                 keep_d;
   logic [PIXEL_WIDTH-1:0] raw_d;

   // Outside a frame a pixel leaves as meta while filtering
   assign dtype_in = (enable && dvi && (dtypei == filter_pkg::dtype_pixel) && !pix_accept) ?
                     filter_pkg::dtype_meta : dtypei;

   filter_regs #(.MAX_COLS(MAX_COLS)) u_regs (
      .clk(clk), .resetb(resetb),
      .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
      .pready(pready), .pslverr(pslverr),
      .enable(enable), .coeffs(coeffs), .num_cols(num_cols)
   );

   stream_decode #(.MAX_COLS(MAX_COLS)) u_decode (
      .clk(clk), .resetb(resetb), .enable(enable), .num_cols(num_cols),
      .dvi(dvi), .dtypei(dtypei), .pix_accept(pix_accept),
      .col_idx(col_idx), .win_valid(), .keep(keep)
   );

   kernel_window #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) u_window (
      .clk(clk), .resetb(resetb), .pix_accept(pix_accept),
      .col_idx(col_idx), .datai(datai), .window(window)
   );

   filter2d_execute #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_execute (
      .clk(clk), .resetb(resetb), .coeffs(coeffs),
      .window(window), .datao(filt_data)
   );

   delay_line #(.payload_t(filter_pkg::dtype_t), .DEPTH(SIDE_DEPTH)) u_dtype_dly (
      .clk(clk), .resetb(resetb), .din(dtype_in), .dout(dtype_d)
   );

   delay_line #(.payload_t(logic), .DEPTH(SIDE_DEPTH)) u_keep_dly (
      .clk(clk), .resetb(resetb), .din(keep), .dout(keep_d)
   );

   delay_line #(.payload_t(logic [PIXEL_WIDTH-1:0]), .DEPTH(SIDE_DEPTH)) u_raw_dly (
      .clk(clk), .resetb(resetb), .din(datai), .dout(raw_d)
   );

   filter_result #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_result (
      .clk(clk), .resetb(resetb), .enable(enable),
      .keep_d(keep_d), .dtype_d(dtype_d), .raw_d(raw_d), .filt_data(filt_data),
      .dvo(dvo), .dtypeo(dtypeo), .datao(datao)
   );

endmodule

//--- verif/filter2d_sva.sv
`timescale 1ns/100ps

module filter2d_sva #(
   parameter int PIXEL_WIDTH = filter_pkg::pixel_width,
   parameter int MAX_COLS    = 64,
   localparam int COL_WIDTH  = $clog2(MAX_COLS + 1)
) (
   input logic                   clk,
   input logic                   resetb,
   input logic                   psel,
   input logic                   penable,
   input logic                   pwrite,
   input logic [7:0]             paddr,
   input logic [31:0]            pwdata,
   input logic [31:0]            prdata,
   input logic                   pslverr,
   input logic                   dvi,
   input filter_pkg::dtype_t     dtypei,
   input logic [PIXEL_WIDTH-1:0] datai,
   input logic                   dvo,
   input filter_pkg::dtype_t     dtypeo,
   input logic [PIXEL_WIDTH-1:0] datao,
   input logic                   enable,
   input logic [filter_pkg::kernel_size-1:0][filter_pkg::coeff_width-1:0] coeffs,
   input logic [COL_WIDTH-1:0]   num_cols
);

   localparam int D = filter_pkg::pipe_latency;
   localparam logic [PIXEL_WIDTH-1:0] PIX_MAX = '1;

   int unsigned            fails = 0;
   logic [31:0]            reg_sh [5];                // Expected read-back per register slot
   logic [4:0]             reg_known;
   logic [2:0]             slot;
   logic                   mapped;
   logic                   in_frame;
   int unsigned            pix_cnt;
   int unsigned            out_pix;
   int unsigned            cols;
   logic [PIXEL_WIDTH-1:0] hist [MAX_COLS+1];         // hist[k] arrived k+1 pixels ago
   logic [PIXEL_WIDTH-1:0] flat_val;
   logic                   flat;
   logic                   pix_in;
   logic                   interior;
   logic [9:0]             csum;
   logic                   exp_keep;
   logic                   exp_chk;
   filter_pkg::dtype_t     exp_dt;
   logic [PIXEL_WIDTH-1:0] exp_data;
   logic [D-1:0]           sh_out;
   logic [D-1:0]           sh_chk;
   filter_pkg::dtype_t     sh_dt [D];
   logic [PIXEL_WIDTH-1:0] sh_data [D];

   function automatic void count_failure(input string msg);
      $error("[FAIL] %0t: %s", $time, msg);
      fails++;
   endfunction

   assign slot     = paddr[4:2];
   assign mapped   = (paddr[7:5] == 3'd0) && (paddr[1:0] == 2'd0) && (slot <= 3'd4);
   assign cols     = 32'(num_cols);
   assign pix_in   = dvi && (dtypei == filter_pkg::dtype_pixel) && in_frame;
   assign interior = pix_in && (pix_cnt / cols >= 2) && (pix_cnt % cols >= 2);
   assign csum     = 10'(coeffs[0]) + 10'(coeffs[1]) + 10'(coeffs[2]);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         reg_sh    <= '{32'd0, 32'd0, 32'd128, 32'd0, 32'd0};   // Filter off with identity kernel
         reg_known <= 5'b01111;                     // Column count known once written
      end else if (psel && penable && pwrite && mapped) begin
         reg_sh[slot]    <= (slot == 3'd0) ? {31'd0, pwdata[0]} :
                            (slot == 3'd4) ? pwdata : {24'd0, pwdata[7:0]};
         reg_known[slot] <= 1'b1;
      end
   end

   // Expected output token for the token at the input
   always_comb begin
      exp_keep = !enable || !pix_in || interior;
      exp_dt   = (enable && dvi && dtypei == filter_pkg::dtype_pixel && !in_frame) ?
                 filter_pkg::dtype_meta : dtypei;
      exp_chk  = 1'b1;
      exp_data = datai;
      if (enable && pix_in) begin
         if (coeffs == {8'd0, 8'd128, 8'd0}) begin
            exp_data = hist[num_cols];              // One row and one column back
         end else if (flat && datai == flat_val &&
                      (csum == 10'd128 || (csum > 10'd128 && datai == PIX_MAX))) begin
            exp_data = flat_val;                    // Flat field holds or saturates
         end else begin
            exp_chk = 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         in_frame <= 1'b0;
         pix_cnt  <= 0;
         out_pix  <= 0;
         flat     <= 1'b0;
         sh_out   <= '0;
         sh_chk   <= '0;
      end else begin
         if (dvi && dtypei == filter_pkg::dtype_frame_start) begin
            in_frame <= 1'b1;
            pix_cnt  <= 0;
         end else if (dvi && dtypei == filter_pkg::dtype_frame_end) begin
            in_frame <= 1'b0;
         end else if (pix_in) begin
            pix_cnt <= pix_cnt + 1;
            flat    <= (pix_cnt == 0) || (flat && datai == flat_val);
         end
         if (dvo && dtypeo == filter_pkg::dtype_frame_start) begin
            out_pix <= 0;
         end else if (dvo && dtypeo == filter_pkg::dtype_pixel) begin
            out_pix <= out_pix + 1;
         end
         sh_out <= {sh_out[D-2:0], dvi && exp_keep};
         sh_chk <= {sh_chk[D-2:0], exp_chk};
      end
   end

   always_ff @(posedge clk) begin
      if (pix_in) begin
         flat_val <= datai;
         hist[0]  <= datai;
         for (int i = 1; i <= MAX_COLS; i++) begin
            hist[i] <= hist[i-1];
         end
      end
      sh_dt[0]   <= exp_dt;
      sh_data[0] <= exp_data;
      for (int i = 1; i < D; i++) begin
         sh_dt[i]   <= sh_dt[i-1];
         sh_data[i] <= sh_data[i-1];
      end
   end

   a_reset: assert property (@(posedge clk) !resetb |-> !dvo && !enable && !pslverr &&
      dtypeo == filter_pkg::dtype_frame_start && datao == '0)
      else count_failure("outputs or enable not cleared during reset");
   a_read: assert property (@(posedge clk) disable iff (!resetb)
      psel && penable && !pwrite && mapped && reg_known[slot] |-> prdata == reg_sh[slot])
      else count_failure("register read-back differs from last write");
   a_unmapped: assert property (@(posedge clk) disable iff (!resetb)
      psel && penable |-> (pslverr == !mapped) && (mapped || prdata == '0))
      else count_failure("pslverr does not follow the address map or unmapped data is nonzero");
   a_valid: assert property (@(posedge clk) disable iff (!resetb) dvo == sh_out[D-1])
      else count_failure("dvo does not follow the input token four clocks back");
   a_token: assert property (@(posedge clk) disable iff (!resetb) sh_out[D-1] |->
      dtypeo == sh_dt[D-1] && (!sh_chk[D-1] || datao == sh_data[D-1]))
      else count_failure("output token type or data mismatch");
   a_count: assert property (@(posedge clk) disable iff (!resetb)
      dvo && dtypeo == filter_pkg::dtype_frame_end && enable |->
      out_pix == (pix_cnt / cols - 2) * (cols - 2))
      else count_failure("output pixel count in frame is not (rows-2)*(cols-2)");

endmodule

bind filter2d_top filter2d_sva #(.PIXEL_WIDTH(PIXEL_WIDTH), .MAX_COLS(MAX_COLS)) u_sva (
   .clk(clk), .resetb(resetb), .psel(psel), .penable(penable), .pwrite(pwrite),
   .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
   .dvi(dvi), .dtypei(dtypei), .datai(datai),
   .dvo(dvo), .dtypeo(dtypeo), .datao(datao),
   .enable(enable), .coeffs(coeffs), .num_cols(num_cols)
);

//--- verif/filter2d_tb.sv
`timescale 1ns/100ps

module filter2d_tb;

   localparam int PERIOD       = 4;
   localparam int COLS         = 6;
   localparam int ROWS         = 5;
   localparam int NUM_FRAMES   = 5;
   localparam int FRAME_CYCLES = 2 * (ROWS * COLS + 4) + 16;   // Gaps and drain included
   localparam int SETUP_CYCLES = 150;                          // Reset and APB traffic
   localparam int TIMEOUT_NS   = PERIOD * (NUM_FRAMES * FRAME_CYCLES + SETUP_CYCLES) + 400;
   localparam int EXP_TOKENS   = (ROWS * COLS + 4) +
                                 (NUM_FRAMES - 1) * ((ROWS - 2) * (COLS - 2) + 4);

   logic               clk;
   logic               resetb;
   logic               psel;
   logic               penable;
   logic               pwrite;
   logic [7:0]         paddr;
   logic [31:0]        pwdata;
   logic [31:0]        prdata;
   logic               pready;
   logic               pslverr;
   logic               dvi;
   filter_pkg::dtype_t dtypei;
   logic [7:0]         datai;
   logic               dvo;
   filter_pkg::dtype_t dtypeo;
   logic [7:0]         datao;
   int                 seed;
   int                 tb_errors;
   int                 out_tokens = 0;

   filter2d_top #(.PIXEL_WIDTH(8), .MAX_COLS(64)) dut0 (.*);

   always #(PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      if (resetb && dvo) out_tokens <= out_tokens + 1;
   end

   task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata);
      int waits;
      waits = 0;
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      while (!pready && waits < 16) begin
         @(negedge clk);
         waits++;
      end
      if (!pready) begin
         $display("APB access to address %h never saw pready", addr);
         tb_errors++;
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
      apb_transfer(1'b1, addr, wdata);
   endtask

   task automatic apb_read(input logic [7:0] addr);
      apb_transfer(1'b0, addr, 32'd0);
   endtask

   task automatic load_coeffs(input logic [7:0] c0, input logic [7:0] c1, input logic [7:0] c2);
      apb_write(filter_pkg::addr_coeff0, {24'd0, c0});
      apb_write(filter_pkg::addr_coeff1, {24'd0, c1});
      apb_write(filter_pkg::addr_coeff2, {24'd0, c2});
   endtask

   task automatic send(input filter_pkg::dtype_t kind, input logic [7:0] value);
      @(negedge clk);
      dvi    = 1'b1;
      dtypei = kind;
      datai  = value;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         dvi = 1'b0;
      end
   endtask

   // Random or flat frame with optional idle gaps between pixels
   task automatic send_frame(input bit flat, input logic [7:0] level, input bit gaps);
      send(filter_pkg::dtype_frame_start, 8'd0);
      send(filter_pkg::dtype_meta, 8'($random(seed)));
      for (int r = 0; r < ROWS; r++) begin
         for (int c = 0; c < COLS; c++) begin
            if (gaps && (($random(seed) & 3) == 0)) idle(1);
            if (r == 2 && c == 0) send(filter_pkg::dtype_meta, 8'($random(seed)));
            send(filter_pkg::dtype_pixel, flat ? level : 8'($random(seed)));
         end
      end
      send(filter_pkg::dtype_frame_end, 8'd0);
      idle(8);                                        // Drain before any reconfiguration
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns before the test sequence ended", TIMEOUT_NS);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      seed      = 4846;
      tb_errors = 0;
      clk       = 1'b0;
      resetb    = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = 8'd0;
      pwdata    = 32'd0;
      dvi       = 1'b0;
      dtypei    = filter_pkg::dtype_frame_start;
      datai     = 8'd0;
      #1 resetb = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk) resetb = 1'b1;
      apb_read(filter_pkg::addr_ctrl);                // Reset values
      apb_read(filter_pkg::addr_coeff0);
      apb_read(filter_pkg::addr_coeff1);
      apb_read(filter_pkg::addr_coeff2);
      apb_write(filter_pkg::addr_cols, COLS);
      apb_read(filter_pkg::addr_cols);
      load_coeffs(8'h5A, 8'hC3, 8'h17);
      apb_write(8'h14, 32'hFFFF_FFFF);                // Unmapped
      apb_read(filter_pkg::addr_coeff0);
      apb_read(filter_pkg::addr_coeff1);
      apb_read(filter_pkg::addr_coeff2);
      apb_read(filter_pkg::addr_ctrl);
      apb_read(filter_pkg::addr_cols);
      apb_read(8'h14);
      apb_read(8'h41);
      load_coeffs(8'd0, 8'd128, 8'd0);
      send_frame(1'b0, 8'd0, 1'b1);                   // Bypass
      apb_write(filter_pkg::addr_ctrl, 32'd1);
      apb_read(filter_pkg::addr_ctrl);
      send_frame(1'b0, 8'd0, 1'b0);
      send_frame(1'b0, 8'd0, 1'b1);
      load_coeffs(8'd32, 8'd64, 8'd32);
      send_frame(1'b1, 8'($random(seed)), 1'b0);
      load_coeffs(8'd255, 8'd255, 8'd255);
      send_frame(1'b1, 8'hFF, 1'b1);
      idle(8);
      if (out_tokens != EXP_TOKENS) begin
         $display("[FAIL] %0t: %0d output tokens, expected %0d", $time, out_tokens, EXP_TOKENS);
         tb_errors++;
      end
      $display("Errors: %0d assertion failures, %0d testbench errors",
               dut0.u_sva.fails, tb_errors);
      if (dut0.u_sva.fails == 0 && tb_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
verilog/filter_pkg.sv
verilog/filter_regs.sv
verilog/stream_decode.sv
verilog/kernel_window.sv
verilog/filter1d.sv
verilog/filter2d_execute.sv
verilog/delay_line.sv
verilog/filter_result.sv
verilog/filter2d_top.sv
verif/filter2d_sva.sv
verif/filter2d_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the filter testbench with Verilator, run it and scan the log
verilator --binary --timing --assert --top-module filter2d_tb -f vlog.f -o filter2d_sim \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/filter2d_sim +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "Simulator returned a non-zero status"
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result line in sim.log"; exit 1; }
echo "Simulation passed"
